//--- hdl/flow_pkg.sv
package flow_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------

  // Data word carried on the push side
  localparam int WordWidth = 16;
  // Result word produced by a lane
  localparam int ResultWidth = 16;

  // --------------------------------------------------------------------------
  // Encodings
  // --------------------------------------------------------------------------

  // Operation applied by a lane to its word
  typedef enum logic [1:0] {
    op_add  = 2'd0,
    op_xor  = 2'd1,
    op_swap = 2'd2,
    op_popc = 2'd3
  } op_t;

  // Lane identity, also the output tag
  typedef enum logic {
    lane_0 = 1'b0,
    lane_1 = 1'b1
  } lane_t;

  // Result of one opcode on one word
  function automatic logic [ResultWidth-1:0] apply_op(op_t op, logic [WordWidth-1:0] word);
    logic [7:0] hi;
    logic [7:0] lo;
    logic [ResultWidth-1:0] res;
    hi  = word[15:8];
    lo  = word[7:0];
    res = '0;
    case (op)
      // Byte sum, carry lands in bit 8
      op_add: res = ResultWidth'(hi) + ResultWidth'(lo);
      op_xor: res = ResultWidth'(hi ^ lo);
      op_swap: res = {lo, hi};
      // Ones count over the full word
      op_popc: begin
        for (int i = 0; i < WordWidth; i++) begin
          res = res + ResultWidth'(word[i]);
        end
      end
      default: res = '0;
    endcase
    return res;
  endfunction

endpackage

//--- hdl/flow_ifs.sv
`timescale 1ns/100ps

// --------------------------------------------------------------------------
// Item stream from the fork into one lane
// --------------------------------------------------------------------------
interface flow_if #(
  parameter int WordWidth = flow_pkg::WordWidth
);
  import flow_pkg::*;

  // Handshake
  logic valid;
  logic ready;
  // Payload
  op_t op;
  logic [WordWidth-1:0] data;

  // Fork side drives valid and payload
  modport src (
    output valid,
    output op,
    output data,
    input  ready
  );

  // Lane side answers with ready
  modport snk (
    input  valid,
    input  op,
    input  data,
    output ready
  );

endinterface

// --------------------------------------------------------------------------
// Result stream from one lane into the merge
// --------------------------------------------------------------------------
interface result_if;
  import flow_pkg::*;

  logic valid;
  logic ready;
  lane_t lane;
  logic [ResultWidth-1:0] result;

  modport src (
    output valid,
    output lane,
    output result,
    input  ready
  );

  modport snk (
    input  valid,
    input  lane,
    input  result,
    output ready
  );

endinterface

//--- hdl/flow_fork_select.sv
`timescale 1ns/100ps

module flow_fork_select #(
  parameter int WordWidth = flow_pkg::WordWidth
) (
  input  logic                 push_valid,
  input  logic [1:0]           push_select,
  output logic                 push_ready,
  flow_if.src                  lane_a,
  flow_if.src                  lane_b,
  input  flow_pkg::op_t        push_op,
  input  logic [WordWidth-1:0] push_data
);

  // --------------------------------------------------------------------------
  // Flow control
  // --------------------------------------------------------------------------

  // Select bits qualified by push_valid
  logic [1:0] push_valid_multihot;
  // Lane readies and valids as vectors, bit 0 is lane a
  logic [1:0] pop_ready;
  logic [1:0] pop_valid;

  // Forces lane valids to 0 when push_valid is low and select is unknown
  assign push_valid_multihot = push_valid ? push_select : 2'b00;

  assign pop_ready = {lane_b.ready, lane_a.ready};

  // Push completes only if every selected lane can take the item now
  always_comb begin
    push_ready = 1'b1;
    for (int i = 0; i < 2; i++) begin
      push_ready &= push_valid_multihot[i] ? pop_ready[i] : 1'b1;
    end
  end

  // A lane sees valid only while the other selected lane is ready too
  // These valids can fall without a transfer when the other ready drops
  always_comb begin
    pop_valid[0] = push_valid_multihot[0] && (!push_valid_multihot[1] || pop_ready[1]);
    pop_valid[1] = push_valid_multihot[1] && (!push_valid_multihot[0] || pop_ready[0]);
  end

  assign lane_a.valid = pop_valid[0];
  assign lane_b.valid = pop_valid[1];

  // --------------------------------------------------------------------------
  // Payload fan-out
  // --------------------------------------------------------------------------

  // Same item to both lanes, valid decides who takes it
  assign lane_a.op   = push_op;
  assign lane_a.data = push_data;
  assign lane_b.op   = push_op;
  assign lane_b.data = push_data;

endmodule

//--- hdl/flow_lane.sv
`timescale 1ns/100ps

module flow_lane #(
  parameter flow_pkg::lane_t LaneId     = flow_pkg::lane_0,
  parameter int              QueueDepth = 2,
  parameter int              WordWidth  = flow_pkg::WordWidth
) (
  input logic clk,
  input logic reset,
  flow_if.snk push,
  result_if.src pop
);
  import flow_pkg::*;

  // Pointer at least one bit wide, also for a single entry
  localparam int PtrWidth   = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int CountWidth = $clog2(QueueDepth + 1);

  // --------------------------------------------------------------------------
  // Queue storage and control
  // --------------------------------------------------------------------------

  op_t                  q_op   [QueueDepth];
  logic [WordWidth-1:0] q_data [QueueDepth];

  logic [PtrWidth-1:0]   rd_ptr;
  logic [PtrWidth-1:0]   wr_ptr;
  logic [CountWidth-1:0] count;

  logic queue_empty;
  logic queue_full;
  logic push_fire;
  logic pop_fire;

  // Head of the queue, or the incoming item when the queue is empty
  op_t                  head_op;
  logic [WordWidth-1:0] head_data;
  logic                 head_avail;

  // Output stage moves
  logic load;
  logic bypass;
  logic q_wr;
  logic q_rd;

  // Output register
  logic                   out_valid_q;
  logic [ResultWidth-1:0] out_result_q;

  // Next pointer with wrap for any depth
  function automatic logic [PtrWidth-1:0] ptr_inc(logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(QueueDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign queue_empty = (count == '0);
  assign queue_full  = (count == CountWidth'(QueueDepth));

  // Ready comes only from the queue fill level
  assign push.ready = !queue_full;
  assign push_fire  = push.valid && push.ready;
  assign pop_fire   = out_valid_q && pop.ready;

  always_comb begin
    head_op    = queue_empty ? push.op : q_op[rd_ptr];
    head_data  = queue_empty ? push.data : q_data[rd_ptr];
    head_avail = !queue_empty || push.valid;
  end

  // Output register takes a new entry when empty or draining this cycle
  assign load   = head_avail && (!out_valid_q || pop.ready);
  // Empty queue lets the pushed item go straight to the output register
  assign bypass = queue_empty && load;
  assign q_wr   = push_fire && !bypass;
  assign q_rd   = load && !queue_empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (q_wr) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (q_rd) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count <= count + CountWidth'(q_wr) - CountWidth'(q_rd);
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (q_wr) begin
      q_op[wr_ptr]   <= push.op;
      q_data[wr_ptr] <= push.data;
    end
  end

  // --------------------------------------------------------------------------
  // Result stage
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid_q <= 1'b0;
    end else if (load) begin
      out_valid_q <= 1'b1;
    end else if (pop_fire) begin
      out_valid_q <= 1'b0;
    end
  end

  // Opcode evaluated on entry, so a stalled result holds still
  always_ff @(posedge clk) begin
    if (load) begin
      out_result_q <= apply_op(head_op, head_data);
    end
  end

  assign pop.valid  = out_valid_q;
  assign pop.lane   = LaneId;
  assign pop.result = out_result_q;

endmodule

//--- hdl/flow_merge_rr.sv
`timescale 1ns/100ps

module flow_merge_rr (
  input  logic                             clk,
  input  logic                             reset,
  result_if.snk                            in_a,
  result_if.snk                            in_b,
  output logic                             out_valid,
  output flow_pkg::lane_t                  out_lane,
  output logic [flow_pkg::ResultWidth-1:0] out_result,
  input  logic                             out_ready
);
  import flow_pkg::*;

  // --------------------------------------------------------------------------
  // Arbitration
  // --------------------------------------------------------------------------

  // Lane preferred when both inputs are valid
  lane_t prio;

  // Output register is empty or drains this cycle
  logic out_free;
  logic take_a;
  logic take_b;

  // Output register
  logic                   out_valid_q;
  lane_t                  out_lane_q;
  logic [ResultWidth-1:0] out_result_q;

  assign out_free = !out_valid_q || out_ready;

  // An input is ready when it holds priority or the other side is idle
  // Never both taken in one cycle since the other side must be idle then
  assign in_a.ready = out_free && ((prio == lane_0) || !in_b.valid);
  assign in_b.ready = out_free && ((prio == lane_1) || !in_a.valid);

  assign take_a = in_a.valid && in_a.ready;
  assign take_b = in_b.valid && in_b.ready;

  // Pointer moves only on a grant, away from the lane just served
  always_ff @(posedge clk) begin
    if (reset) begin
      prio <= lane_0;
    end else if (take_a) begin
      prio <= lane_1;
    end else if (take_b) begin
      prio <= lane_0;
    end
  end

  // --------------------------------------------------------------------------
  // Output stage
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid_q <= 1'b0;
    end else if (take_a || take_b) begin
      out_valid_q <= 1'b1;
    end else if (out_ready) begin
      out_valid_q <= 1'b0;
    end
  end

  // Winner payload, held while out_ready is low
  always_ff @(posedge clk) begin
    if (take_a) begin
      out_lane_q   <= in_a.lane;
      out_result_q <= in_a.result;
    end else if (take_b) begin
      out_lane_q   <= in_b.lane;
      out_result_q <= in_b.result;
    end
  end

  assign out_valid  = out_valid_q;
  assign out_lane   = out_lane_q;
  assign out_result = out_result_q;

endmodule

//--- hdl/flow_fork_top.sv
`timescale 1ns/100ps

module flow_fork_top #(
  parameter int WordWidth  = flow_pkg::WordWidth,
  parameter int QueueDepth = 2
) (
  input  logic                             clk,
  input  logic                             reset,
  // Push side
  input  logic                             push_valid,
  output logic                             push_ready,
  input  flow_pkg::op_t                    push_op,
  input  logic [1:0]                       push_select,
  input  logic [WordWidth-1:0]             push_data,
  // Merged output side
  output logic                             out_valid,
  input  logic                             out_ready,
  output flow_pkg::lane_t                  out_lane,
  output logic [flow_pkg::ResultWidth-1:0] out_result
);
  import flow_pkg::*;

  // --------------------------------------------------------------------------
  // Internal streams
  // --------------------------------------------------------------------------

  // Fork to lanes
  flow_if #(.WordWidth(WordWidth)) lane_0_in ();
  flow_if #(.WordWidth(WordWidth)) lane_1_in ();

  // Lanes to merge
  result_if lane_0_res ();
  result_if lane_1_res ();

  // --------------------------------------------------------------------------
  // Blocks
  // --------------------------------------------------------------------------

  // Stateless multicast of each push item
  flow_fork_select #(
    .WordWidth(WordWidth)
  ) u_fork (
    .push_valid  (push_valid),
    .push_select (push_select),
    .push_ready  (push_ready),
    .lane_a      (lane_0_in),
    .lane_b      (lane_1_in),
    .push_op     (push_op),
    .push_data   (push_data)
  );

  flow_lane #(
    .LaneId     (lane_0),
    .QueueDepth (QueueDepth),
    .WordWidth  (WordWidth)
  ) u_lane_0 (
    .clk   (clk),
    .reset (reset),
    .push  (lane_0_in),
    .pop   (lane_0_res)
  );

  flow_lane #(
    .LaneId     (lane_1),
    .QueueDepth (QueueDepth),
    .WordWidth  (WordWidth)
  ) u_lane_1 (
    .clk   (clk),
    .reset (reset),
    .push  (lane_1_in),
    .pop   (lane_1_res)
  );

  // Round-robin join back to one stream
  flow_merge_rr u_merge (
    .clk        (clk),
    .reset      (reset),
    .in_a       (lane_0_res),
    .in_b       (lane_1_res),
    .out_valid  (out_valid),
    .out_lane   (out_lane),
    .out_result (out_result),
    .out_ready  (out_ready)
  );

endmodule

//--- testbench/tb_flow_table.svh
  // --------------------------------------------------------------------------
  // Stimulus table
  // --------------------------------------------------------------------------

  // One directed item
  // Results worked out by hand from the opcode rules; hold is out_ready low cycles
  typedef struct {
    string                  name;
    op_t                    op;
    logic [1:0]             sel;
    logic [WordWidth-1:0]   word;
    logic [ResultWidth-1:0] exp_res;
    int                     hold;
  } stim_t;

  localparam int NumEntries = 10;

  stim_t stim_table [NumEntries] = '{
    '{"add_l0",       op_add,  2'b01, 16'h3412, 16'h0046, 0},
    // Byte sum with carry into bit 8
    '{"add_carry_l1", op_add,  2'b10, 16'hf0f0, 16'h01e0, 2},
    '{"xor_l0",       op_xor,  2'b01, 16'ha55a, 16'h00ff, 0},
    '{"xor_l1",       op_xor,  2'b10, 16'h1234, 16'h0026, 3},
    '{"swap_l0",      op_swap, 2'b01, 16'hbeef, 16'hefbe, 0},
    '{"swap_both",    op_swap, 2'b11, 16'h00c3, 16'hc300, 1},
    '{"popc_l1",      op_popc, 2'b10, 16'hf00f, 16'h0008, 0},
    // All ones, full count
    '{"popc_both",    op_popc, 2'b11, 16'hffff, 16'h0010, 4},
    '{"popc_l0",      op_popc, 2'b01, 16'h0001, 16'h0001, 0},
    '{"add_both",     op_add,  2'b11, 16'hffff, 16'h01fe, 2}
  };

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------

  task automatic compare_result(input string name,
                                input logic [ResultWidth-1:0] exp_val,
                                input logic [ResultWidth-1:0] act_val);
    if (act_val !== exp_val) begin
      value_errors++;
      $display("ERR %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  task automatic compare_lane(input string name, input lane_t exp_val, input lane_t act_val);
    if (act_val !== exp_val) begin
      value_errors++;
      $display("ERR %s: expected lane %0d, actual lane %0d", name, exp_val, act_val);
    end
  endtask

  task automatic compare_flag(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      value_errors++;
      $display("ERR %s: expected %b, actual %b", name, exp_val, act_val);
    end
  endtask

//--- testbench/tb_flow_fork_top.sv
`timescale 1ns/100ps

module tb_flow_fork_top;
  import flow_pkg::*;

  localparam int QueueDepth = 2;

  logic                   clk;
  logic                   reset;
  logic                   push_valid;
  logic                   push_ready;
  op_t                    push_op;
  logic [1:0]             push_select;
  logic [WordWidth-1:0]   push_data;
  logic                   out_valid;
  logic                   out_ready;
  lane_t                  out_lane;
  logic [ResultWidth-1:0] out_result;

  int          value_errors;
  int          other_errors;
  integer      seed;
  logic [31:0] rnd;
  // Random out_ready on each falling edge while set
  logic        rand_ready;

  // Expected results, one queue per lane in push order
  typedef struct {
    string                  name;
    lane_t                  lane;
    logic [ResultWidth-1:0] result;
  } exp_t;

  exp_t exp_q0 [$];
  exp_t exp_q1 [$];

  // Output seen on the last edge while stalled
  logic                   prev_stall;
  lane_t                  prev_lane;
  logic [ResultWidth-1:0] prev_result;

  `include "tb_flow_table.svh"

  flow_fork_top #(
    .WordWidth  (WordWidth),
    .QueueDepth (QueueDepth)
  ) u_flow_fork_top (
    .clk         (clk),
    .reset       (reset),
    .push_valid  (push_valid),
    .push_ready  (push_ready),
    .push_op     (push_op),
    .push_select (push_select),
    .push_data   (push_data),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_lane    (out_lane),
    .out_result  (out_result)
  );

  always #5 clk = ~clk;

  always @(negedge clk) begin
    if (rand_ready) begin
      rnd       = $random(seed);
      out_ready = rnd[0];
    end
  end

  // --------------------------------------------------------------------------
  // Output monitor
  // --------------------------------------------------------------------------

  task automatic check_output();
    exp_t item;
    if (out_lane === lane_0 && exp_q0.size() > 0) begin
      item = exp_q0.pop_front();
    end else if (out_lane === lane_1 && exp_q1.size() > 0) begin
      item = exp_q1.pop_front();
    end else if (exp_q0.size() > 0 || exp_q1.size() > 0) begin
      // Tag names a lane with nothing pending, the oldest open item gives the lane
      if (exp_q0.size() > 0) begin
        item = exp_q0[0];
      end else begin
        item = exp_q1[0];
      end
      compare_lane(item.name, item.lane, out_lane);
      return;
    end else begin
      other_errors++;
      $display("Output on lane %0d arrived with no result expected there", out_lane);
      return;
    end
    compare_result(item.name, item.result, out_result);
  endtask

  always @(posedge clk) begin
    if (reset) begin
      prev_stall = 1'b0;
    end else begin
      // A stalled output must hold its payload
      if (prev_stall) begin
        if (out_valid !== 1'b1) begin
          other_errors++;
          $display("out_valid dropped while out_ready was low");
        end
        compare_lane("stall_hold", prev_lane, out_lane);
        compare_result("stall_hold", prev_result, out_result);
      end
      if (out_valid === 1'b1 && out_ready) begin
        check_output();
      end
      prev_stall  = (out_valid === 1'b1) && !out_ready;
      prev_lane   = out_lane;
      prev_result = out_result;
    end
  end

  // --------------------------------------------------------------------------
  // Push side
  // --------------------------------------------------------------------------

  // Drive one table item and book its expected results
  task automatic present_item(input int idx);
    exp_t item;
    push_valid     = 1'b1;
    push_op        = stim_table[idx].op;
    push_select    = stim_table[idx].sel;
    push_data      = stim_table[idx].word;
    item.name      = stim_table[idx].name;
    item.result    = stim_table[idx].exp_res;
    if (stim_table[idx].sel[0]) begin
      item.lane = lane_0;
      exp_q0.push_back(item);
    end
    if (stim_table[idx].sel[1]) begin
      item.lane = lane_1;
      exp_q1.push_back(item);
    end
  endtask

  // Transfer seen at the rising edge, returns on the next falling edge
  task automatic wait_accept(input int max_cycles, output logic ok);
    ok = 1'b0;
    for (int i = 0; i < max_cycles && !ok; i++) begin
      @(posedge clk);
      ok = push_ready;
      @(negedge clk);
    end
    if (ok) begin
      push_valid = 1'b0;
    end
  endtask

  task automatic push_entry(input int idx, input int max_cycles);
    logic ok;
    present_item(idx);
    wait_accept(max_cycles, ok);
    if (!ok) begin
      other_errors++;
      $display("Push of %s was not accepted within %0d cycles", stim_table[idx].name,
               max_cycles);
      push_valid = 1'b0;
    end
  endtask

  task automatic wait_drain(input int max_cycles);
    int n;
    n = 0;
    while ((exp_q0.size() > 0 || exp_q1.size() > 0 || out_valid !== 1'b0) &&
           n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (exp_q0.size() > 0 || exp_q1.size() > 0 || out_valid !== 1'b0) begin
      other_errors++;
      $display("Results still missing after %0d cycles (lane 0: %0d, lane 1: %0d)",
               max_cycles, exp_q0.size(), exp_q1.size());
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    logic ok;
    logic stalled;
    int   accepted;
    clk          = 1'b0;
    reset        = 1'b1;
    push_valid   = 1'b0;
    push_op      = op_add;
    push_select  = 2'b00;
    push_data    = '0;
    out_ready    = 1'b1;
    rand_ready   = 1'b0;
    seed         = 32'h919c;
    value_errors = 0;
    other_errors = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // Idle state after reset
    compare_flag("reset_out_valid", 1'b0, out_valid);
    compare_flag("reset_push_ready", 1'b1, push_ready);

    // Directed items, each followed by its stall pattern
    for (int e = 0; e < NumEntries; e++) begin
      push_entry(e, 20);
      if (stim_table[e].hold > 0) begin
        out_ready = 1'b0;
        repeat (stim_table[e].hold) @(negedge clk);
        out_ready = 1'b1;
      end
    end
    wait_drain(50);

    // Back-pressure on lane 0 until push_ready falls
    out_ready = 1'b0;
    accepted  = 0;
    stalled   = 1'b0;
    for (int k = 0; k < 8 && !stalled; k++) begin
      present_item((k % 2 == 0) ? 0 : 2);
      wait_accept(6, ok);
      if (ok) begin
        accepted++;
      end else begin
        stalled = 1'b1;
      end
    end
    if (!stalled) begin
      other_errors++;
      $display("push_ready stayed high with out_ready held low");
    end else if (accepted > QueueDepth + 2) begin
      other_errors++;
      $display("Lane took %0d pushes with out_ready held low", accepted);
    end
    repeat (6) @(negedge clk);
    out_ready = 1'b1;
    if (stalled) begin
      wait_accept(20, ok);
      if (!ok) begin
        other_errors++;
        $display("Stalled push was not accepted after out_ready rose");
        push_valid = 1'b0;
      end
    end
    wait_drain(50);

    // Random out_ready over mixed selects
    rand_ready = 1'b1;
    for (int r = 0; r < 3; r++) begin
      for (int e = 0; e < NumEntries; e++) begin
        push_entry(e, 60);
      end
    end
    rand_ready = 1'b0;
    out_ready  = 1'b1;
    wait_drain(200);
    // Catch any late duplicate
    repeat (5) @(negedge clk);

    $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+testbench
hdl/flow_pkg.sv
hdl/flow_ifs.sv
hdl/flow_fork_select.sv
hdl/flow_lane.sv
hdl/flow_merge_rr.sv
hdl/flow_fork_top.sv
testbench/tb_flow_fork_top.sv
